// File: sources.f
logic/corr_pkg.sv
logic/corr_ctrl_if.sv
logic/block_ctrl.sv
logic/correlator.sv
logic/vis_bank_ram.sv
logic/corr_block.sv
logic/corr_top.sv
tests/corr_top_sva.sv
tests/tb_corr_top.sv

// File: Bender.yml
package:
  name: corr_top

sources:
  - logic/corr_pkg.sv
  - logic/corr_ctrl_if.sv
  - logic/block_ctrl.sv
  - logic/correlator.sv
  - logic/vis_bank_ram.sv
  - logic/corr_block.sv
  - logic/corr_top.sv
  - target: test
    files:
      - tests/corr_top_sva.sv
      - tests/tb_corr_top.sv

// File: tests/tb_corr_top.sv
`timescale 1ns/1ps

module tb_corr_top import corr_pkg::*; ();

   // One table row per test phase
   typedef struct packed {
      logic [9:0] n_en;                        // Enabled cycles
      logic       gaps;                        // Random idle cycles in between
      logic       ones;                        // All-ones samples
      logic       sw_en;
      tick_t      sw_tick;                     // Tick at which sw_i is pulsed
      bank_t      rd_bank;                     // Bank read back afterwards
      logic       rd_busy;                     // Keep en_i going during read-back
   } phase_t;

   localparam int NROWS = 6;
   localparam int NSEL  = 2 * NCORR;           // Re/Im per correlator

   // Pair for tick t with the first antenna high and two distinct antennas
   function automatic pair_tab_t build_pairs(input int c);
      pair_tab_t tab;
      ant_t      a;
      ant_t      b;
      tab = '0;
      for (int t = 0; t < TRATE; t++) begin
         a = ant_t'((5 * c + t) % IBITS);
         b = ant_t'((7 * c + 3 * t + 1) % IBITS);
         tab[t*PAIR_BITS +: PAIR_BITS] = {a, b};
      end
      return tab;
   endfunction

   localparam pair_tab_t PAIRS [NCORR] = '{build_pairs(0), build_pairs(1),
                                           build_pairs(2), build_pairs(3)};

   logic      sram_ck_i;
   logic      reset_i;
   logic      en_i;
   logic      sw_i;
   sample_t   re_i;
   sample_t   im_i;
   logic      sram_ce_i;
   sram_adr_t sram_ad_i;
   acc_t      sram_do_o;

   // Reference model state
   integer    seed;
   int        m_tick;
   bank_t     m_bank;
   logic      m_pend;                          // Switch waiting for tick 0
   logic      m_clear;
   acc_t      m_acc [NCORR][TRATE][2];
   acc_t      exp_mem [1 << XBITS][TRATE][NSEL];   // Expected read-back words
   phase_t    phases [NROWS];
   int        n_checks;

   corr_top #(
      .PAIRS0 (PAIRS[0]),
      .PAIRS1 (PAIRS[1]),
      .PAIRS2 (PAIRS[2]),
      .PAIRS3 (PAIRS[3])
   ) DUT (.*);

   bind corr_top corr_top_sva u_sva (
      .sram_ck_i (sram_ck_i),
      .reset_i   (reset_i),
      .rd_en_i   (ctl_bus.rd_en),
      .wr_en_i   (ctl_bus.wr_en),
      .tick_i    (u_ctrl.tick_q),
      .bank_i    (u_ctrl.bank_q)
   );

   initial begin
      sram_ck_i = 1'b0;
      forever #5 sram_ck_i = ~sram_ck_i;      // 10 ns period
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

   task automatic check_acc(input string name, input acc_t got, input acc_t exp);
      n_checks++;
      if (got !== exp) begin
         abort_run($sformatf("error: %s got %h expected %h", name, got, exp));
      end
   endtask

   task automatic check_zero(input string name, input acc_t got);
      n_checks++;
      if (got !== '0) begin
         abort_run($sformatf("error: %s got %h expected %h", name, got, acc_t'(0)));
      end
   endtask

   // ------------------------------------------------------------------------
   // Reference model stepped once per clock edge
   // ------------------------------------------------------------------------
   task automatic model_step(input logic en, input logic sw, input sample_t re,
                             input sample_t im);
      logic apply;
      ant_t a;
      ant_t b;
      acc_t inc_re;
      acc_t inc_im;
      apply = m_pend && (m_tick == 0);
      if (apply) begin
         m_bank  = bank_t'(m_bank + 1'b1);
         m_clear = 1'b1;                       // Next full sweep restarts
      end
      if (en) begin
         for (int c = 0; c < NCORR; c++) begin
            a = PAIRS[c][m_tick*PAIR_BITS + ANT_BITS +: ANT_BITS];
            b = PAIRS[c][m_tick*PAIR_BITS +: ANT_BITS];
            inc_re = acc_t'(re[a] == re[b]) + acc_t'(im[a] == im[b]);
            inc_im = acc_t'(im[a] == re[b]) + acc_t'(re[a] != im[b]);
            m_acc[c][m_tick][0] = m_clear ? inc_re : m_acc[c][m_tick][0] + inc_re;
            m_acc[c][m_tick][1] = m_clear ? inc_im : m_acc[c][m_tick][1] + inc_im;
            exp_mem[m_bank][m_tick][2*c]     = m_acc[c][m_tick][0];
            exp_mem[m_bank][m_tick][2*c + 1] = m_acc[c][m_tick][1];
         end
      end
      m_pend = sw || (m_pend && !apply);
      if (en) begin
         if (m_tick == TRATE - 1) begin
            m_tick  = 0;
            m_clear = 1'b0;
         end else begin
            m_tick++;
         end
      end
   endtask

   // Drives at the falling edge and returns at the next one
   task automatic run_cycle(input logic en, input logic sw, input logic ce,
                            input sram_adr_t ad, input logic ones);
      sample_t re;
      sample_t im;
      re = ones ? '1 : sample_t'($random(seed));
      im = ones ? '1 : sample_t'($random(seed));
      en_i      = en;
      sw_i      = sw;
      re_i      = re;
      im_i      = im;
      sram_ce_i = ce;
      sram_ad_i = ad;
      model_step(en, sw, re, im);
      @(negedge sram_ck_i);
      if (DUT.u_sva.fail_cnt != 0) begin
         abort_run("an assertion in corr_top_sva failed");
      end
   endtask

   task automatic drain();
      int n;
      n = 0;
      while (n < 2 || DUT.ctl_bus.wr_en) begin   // Both write-side stages empty
         if (n == 16) begin
            abort_run("write pipeline did not drain");
         end
         run_cycle(1'b0, 1'b0, 1'b0, '0, 1'b0);
         n++;
      end
   endtask

   // Reads every tick and select of one bank
   task automatic read_bank(input bank_t bank, input logic busy);
      sram_adr_t ad;
      for (int t = 0; t < TRATE; t++) begin
         for (int s = 0; s < NSEL; s++) begin
            ad = {bank, tick_t'(t), SEL_BITS'(s)};
            run_cycle(busy, 1'b0, 1'b1, ad, 1'b0);
            run_cycle(busy, 1'b0, 1'b0, ~ad, 1'b0);   // Output holds with ce low
            run_cycle(busy, 1'b0, 1'b0, ~ad, 1'b0);
            check_acc($sformatf("sram_do_o[bank %0d tick %0d sel %0d]", bank, t, s),
                      sram_do_o, exp_mem[bank][t][s]);
         end
      end
   endtask

   task automatic run_phase(input phase_t ph);
      int guard;
      for (int i = 0; i < int'(ph.n_en); i++) begin
         run_cycle(1'b1, 1'b0, 1'b0, '0, ph.ones);
         if (ph.gaps && (($random(seed) & 3) == 0)) begin
            run_cycle(1'b0, 1'b0, 1'b0, '0, 1'b0);
         end
      end
      if (ph.sw_en) begin
         guard = 0;
         while (m_tick != int'(ph.sw_tick)) begin   // Walk on to the switch tick
            if (guard == 2 * TRATE) begin
               abort_run("tick never reached the switch point");
            end
            run_cycle(1'b1, 1'b0, 1'b0, '0, ph.ones);
            guard++;
         end
         run_cycle(1'b0, 1'b1, 1'b0, '0, 1'b0);
      end
      drain();
      read_bank(ph.rd_bank, ph.rd_busy);
   endtask

   function automatic phase_t mk_row(input int n_en, input logic gaps, input logic ones,
                                     input int sw_tick, input int rd_bank, input logic busy);
      phase_t ph;
      ph.n_en    = 10'(n_en);
      ph.gaps    = gaps;
      ph.ones    = ones;
      ph.sw_en   = (sw_tick >= 0);             // Negative means no switch
      ph.sw_tick = tick_t'(sw_tick < 0 ? 0 : sw_tick);
      ph.rd_bank = bank_t'(rd_bank);
      ph.rd_busy = busy;
      return ph;
   endfunction

   // ------------------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------------------
   initial begin
      seed      = 32'h0cda_add6;
      n_checks  = 0;
      reset_i   = 1'b1;
      en_i      = 1'b0;
      sw_i      = 1'b0;
      re_i      = '0;
      im_i      = '0;
      sram_ce_i = 1'b0;
      sram_ad_i = '0;
      m_tick    = 0;
      m_bank    = '0;
      m_pend    = 1'b0;
      m_clear   = 1'b1;                        // First sweep after reset

      phases[0] = mk_row(TRATE,     1'b0, 1'b1,  0, 0, 1'b0);   // All ones into bank 0
      phases[1] = mk_row(3 * TRATE, 1'b1, 1'b0,  0, 1, 1'b0);   // Random with gaps
      phases[2] = mk_row(2 * TRATE, 1'b0, 1'b0, -1, 1, 1'b1);   // Bank 1 while writing 2
      phases[3] = mk_row(5,         1'b0, 1'b0,  5, 1, 1'b0);   // Mid-sweep switch
      phases[4] = mk_row(TRATE,     1'b1, 1'b0, -1, 2, 1'b0);   // Sweep rest in bank 2
      phases[5] = mk_row(TRATE,     1'b0, 1'b0,  0, 3, 1'b0);   // Cleared bank 3

      for (int i = 0; i < 16; i++) begin
         @(negedge sram_ck_i);
      end
      reset_i = 1'b0;
      check_zero("sram_do_o", sram_do_o);      // No read issued yet

      for (int r = 0; r < NROWS; r++) begin
         run_phase(phases[r]);
      end

      if (n_checks == 1 + NROWS * TRATE * NSEL) begin
         $display("PASS: all tests");
         $finish;
      end else begin
         $display("only %0d checks ran", n_checks);
         $display("FAIL: see errors above");
         $fatal(1);
      end
   end

endmodule

// File: tests/corr_top_sva.sv
`timescale 1ns/1ps

module corr_top_sva import corr_pkg::*; (
   input logic  sram_ck_i,
   input logic  reset_i,
   input logic  rd_en_i,
   input logic  wr_en_i,
   input tick_t tick_i,
   input bank_t bank_i
);

   int fail_cnt = 0;                           // Failed assertions so far

   // Write side trails the read side by both pipeline stages
   a_wr_delay: assert property (@(posedge sram_ck_i) disable iff (reset_i)
      !$past(reset_i) && !$past(reset_i, 2) |-> wr_en_i == $past(rd_en_i, 2))
      else begin
         $error("wr_en is not rd_en delayed by 2 cycles");
         fail_cnt++;
      end

   a_tick_range: assert property (@(posedge sram_ck_i) disable iff (reset_i)
      tick_i < tick_t'(TRATE))                 // Wraps after TRATE-1
      else begin
         $error("tick left the sweep range");
         fail_cnt++;
      end

   // Switch lands only at sweep start
   a_bank_at_zero: assert property (@(posedge sram_ck_i) disable iff (reset_i)
      $changed(bank_i) && !$past(reset_i) |-> $past(tick_i) == '0)
      else begin
         $error("bank changed while the tick was not 0");
         fail_cnt++;
      end

   a_reset_wr: assert property (@(posedge sram_ck_i) reset_i |=> !wr_en_i)
      else begin
         $error("wr_en high in the cycle after reset");
         fail_cnt++;
      end

endmodule

// File: logic/corr_top.sv
`timescale 1ns/1ps

module corr_top import corr_pkg::*; #(
   parameter pair_tab_t PAIRS0 = '0,
   parameter pair_tab_t PAIRS1 = '0,
   parameter pair_tab_t PAIRS2 = '0,
   parameter pair_tab_t PAIRS3 = '0
) (
   input  logic      sram_ck_i,
   input  logic      reset_i,
   input  logic      en_i,                     // Sample valid
   input  logic      sw_i,                     // Bank switch pulse
   input  sample_t   re_i,
   input  sample_t   im_i,
   input  logic      sram_ce_i,
   input  sram_adr_t sram_ad_i,
   output acc_t      sram_do_o                 // 2 cycles after sram_ce_i
);

   corr_ctrl_if ctl_bus ();

   // Tick, bank and write-side timing
   block_ctrl u_ctrl (
      .sram_ck_i (sram_ck_i),
      .reset_i   (reset_i),
      .en_i      (en_i),
      .sw_i      (sw_i),
      .ctl       (ctl_bus.ctrl)
   );

   corr_block #(
      .PAIRS0    (PAIRS0),
      .PAIRS1    (PAIRS1),
      .PAIRS2    (PAIRS2),
      .PAIRS3    (PAIRS3)
   ) u_block (
      .sram_ck_i (sram_ck_i),
      .reset_i   (reset_i),
      .re_i      (re_i),
      .im_i      (im_i),
      .ctl       (ctl_bus.blk),
      .sram_ce_i (sram_ce_i),
      .sram_ad_i (sram_ad_i),
      .sram_do_o (sram_do_o)
   );

endmodule

// File: logic/corr_block.sv
`timescale 1ns/1ps

module corr_block import corr_pkg::*; #(
   parameter pair_tab_t PAIRS0 = '0,
   parameter pair_tab_t PAIRS1 = '0,
   parameter pair_tab_t PAIRS2 = '0,
   parameter pair_tab_t PAIRS3 = '0
) (
   input  logic      sram_ck_i,
   input  logic      reset_i,

   // Shared antenna stream
   input  sample_t   re_i,
   input  sample_t   im_i,

   corr_ctrl_if.blk  ctl,

   // Read-back port
   input  logic      sram_ce_i,
   input  sram_adr_t sram_ad_i,
   output acc_t      sram_do_o
);

   // One table per correlator, index matches the read-back select
   localparam pair_tab_t PAIRS [NCORR] = '{PAIRS0, PAIRS1, PAIRS2, PAIRS3};

   vis_t vis [NCORR];                          // Stage 2 outputs

   // -------------------------------------------------------------------------
   // Correlators, all on the same tick and strobes
   // -------------------------------------------------------------------------
   for (genvar c = 0; c < NCORR; c++) begin : g_corr
      correlator #(
         .PAIRS     (PAIRS[c])
      ) u_corr (
         .sram_ck_i (sram_ck_i),
         .reset_i   (reset_i),
         .re_i      (re_i),
         .im_i      (im_i),
         .ctl       (ctl),
         .vis_o     (vis[c])
      );
   end

   // -------------------------------------------------------------------------
   // Visibility store, one write per processed sample
   // -------------------------------------------------------------------------
   vis_bank_ram u_ram (
      .sram_ck_i (sram_ck_i),
      .reset_i   (reset_i),
      .we_i      (ctl.wr_en),
      .bank_i    (ctl.wr_bank),                // Bank at the sample's rd_en
      .tick_i    (ctl.wr_tick),
      .vis0_i    (vis[0]),
      .vis1_i    (vis[1]),
      .vis2_i    (vis[2]),
      .vis3_i    (vis[3]),
      .sram_ce_i (sram_ce_i),
      .sram_ad_i (sram_ad_i),
      .sram_do_o (sram_do_o)
   );

endmodule

// File: logic/vis_bank_ram.sv
`timescale 1ns/1ps

module vis_bank_ram import corr_pkg::*; (
   input  logic      sram_ck_i,
   input  logic      reset_i,
   input  logic      we_i,                     // All four visibilities at once
   input  bank_t     bank_i,
   input  tick_t     tick_i,
   input  vis_t      vis0_i,
   input  vis_t      vis1_i,
   input  vis_t      vis2_i,
   input  vis_t      vis3_i,
   input  logic      sram_ce_i,
   input  sram_adr_t sram_ad_i,
   output acc_t      sram_do_o
);

   localparam int ABITS = XBITS + TBITS;       // {bank, tick}
   localparam int DEPTH = 1 << ABITS;
   localparam int WBITS = NCORR * $bits(vis_t);

   typedef logic [ABITS-1:0]    ram_adr_t;
   typedef logic [WBITS-1:0]    ram_word_t;
   typedef logic [SEL_BITS-1:0] sel_t;

   ram_word_t mem [DEPTH];

   ram_adr_t  wr_adr;
   ram_adr_t  rd_adr;
   sel_t      rd_sel;
   ram_word_t rd_word_q;                       // First read stage
   sel_t      rd_sel_q;                        // Travels with rd_word_q
   acc_t      rd_mux;

   assign wr_adr = {bank_i, tick_i};
   assign rd_adr = sram_ad_i[$bits(sram_adr_t)-1:SEL_BITS];
   assign rd_sel = sram_ad_i[SEL_BITS-1:0];    // {correlator, Re/Im}

   // Correlator 0 lowest, so the select matches the address layout
   always_ff @(posedge sram_ck_i) begin
      if (we_i) begin
         mem[wr_adr] <= {vis3_i, vis2_i, vis1_i, vis0_i};
      end
   end

   // -------------------------------------------------------------------------
   // Read-back, RAM register then registered 8:1 select
   // -------------------------------------------------------------------------
   always_ff @(posedge sram_ck_i) begin
      if (reset_i) begin
         rd_word_q <= '0;
         rd_sel_q  <= '0;
      end else if (sram_ce_i) begin
         rd_word_q <= mem[rd_adr];
         rd_sel_q  <= rd_sel;
      end
   end

   assign rd_mux = rd_word_q[rd_sel_q*ACCUM +: ACCUM];

   // Holds while the first stage holds
   always_ff @(posedge sram_ck_i) begin
      if (reset_i) begin
         sram_do_o <= '0;
      end else begin
         sram_do_o <= rd_mux;
      end
   end

endmodule

// File: logic/correlator.sv
`timescale 1ns/1ps

module correlator import corr_pkg::*; #(
   parameter pair_tab_t PAIRS = '0             // Antenna pair per tick
) (
   input  logic      sram_ck_i,
   input  logic      reset_i,
   input  sample_t   re_i,
   input  sample_t   im_i,
   corr_ctrl_if.blk  ctl,
   output vis_t      vis_o                     // {imag, real} accumulator value
);

   // Unpacked pair table
   ant_t ant_a [TRATE];
   ant_t ant_b [TRATE];

   ant_t sel_a;
   ant_t sel_b;

   // Single-bit agreements of the selected pair
   logic re_agree;                             // re[a] == re[b]
   logic im_agree;                             // im[a] == im[b]
   logic x_agree;                              // im[a] == re[b]
   logic x_differ;                             // re[a] != im[b]
   inc_t re_inc;
   inc_t im_inc;

   // Per-tick accumulators
   vis_t acc_mem [TRATE];

   // Stage 1 registers
   inc_t s1_re_inc_q;
   inc_t s1_im_inc_q;
   vis_t s1_old_q;
   logic s1_clear_q;

   // Stage 2 arithmetic
   acc_t old_re;
   acc_t old_im;
   acc_t new_re;
   acc_t new_im;

   for (genvar t = 0; t < TRATE; t++) begin : g_pairs
      assign ant_a[t] = PAIRS[t*PAIR_BITS + ANT_BITS +: ANT_BITS];   // High half
      assign ant_b[t] = PAIRS[t*PAIR_BITS +: ANT_BITS];
   end

   // -------------------------------------------------------------------------
   // Stage 1: pair select and increments
   // -------------------------------------------------------------------------
   assign sel_a = ant_a[ctl.rd_tick];
   assign sel_b = ant_b[ctl.rd_tick];

   assign re_agree = (re_i[sel_a] == re_i[sel_b]);
   assign im_agree = (im_i[sel_a] == im_i[sel_b]);
   assign x_agree  = (im_i[sel_a] == re_i[sel_b]);
   assign x_differ = (re_i[sel_a] != im_i[sel_b]);

   assign re_inc = {1'b0, re_agree} + {1'b0, im_agree};     // 0 to 2
   assign im_inc = {1'b0, x_agree} + {1'b0, x_differ};

   always_ff @(posedge sram_ck_i) begin
      if (ctl.rd_en) begin
         s1_re_inc_q <= re_inc;
         s1_im_inc_q <= im_inc;
         s1_old_q    <= acc_mem[ctl.rd_tick];  // Write lands 2 edges later
      end
   end

   always_ff @(posedge sram_ck_i) begin
      if (reset_i) begin
         s1_clear_q <= 1'b1;
      end else if (ctl.rd_en) begin
         s1_clear_q <= ctl.clear;
      end
   end

   // -------------------------------------------------------------------------
   // Stage 2: accumulate, or restart under clear
   // -------------------------------------------------------------------------
   assign old_re = s1_old_q[ACCUM-1:0];
   assign old_im = s1_old_q[2*ACCUM-1:ACCUM];

   assign new_re = s1_clear_q ? acc_t'(s1_re_inc_q)
                              : acc_t'(old_re + acc_t'(s1_re_inc_q));   // Wraps
   assign new_im = s1_clear_q ? acc_t'(s1_im_inc_q)
                              : acc_t'(old_im + acc_t'(s1_im_inc_q));

   always_ff @(posedge sram_ck_i) begin
      vis_o <= {new_im, new_re};
   end

   // Same value the RAM takes at this edge
   always_ff @(posedge sram_ck_i) begin
      if (ctl.wr_en) begin
         acc_mem[ctl.wr_tick] <= vis_o;
      end
   end

endmodule

// File: logic/block_ctrl.sv
`timescale 1ns/1ps

module block_ctrl import corr_pkg::*; (
   input  logic      sram_ck_i,
   input  logic      reset_i,
   input  logic      en_i,                     // One pair-tick per cycle
   input  logic      sw_i,                     // Bank switch request
   corr_ctrl_if.ctrl ctl
);

   tick_t tick_q;
   bank_t bank_q;
   logic  sw_pend_q;                           // Switch waiting for tick 0
   logic  clear_q;
   logic  tick_last;
   logic  sw_apply;
   bank_t bank_rd;                             // Bank seen by this cycle's sample

   // Write-side delay line
   logic  en_d1_q, en_d2_q;
   tick_t tick_d1_q, tick_d2_q;
   bank_t bank_d1_q, bank_d2_q;

   assign tick_last = (tick_q == tick_t'(TRATE - 1));
   assign sw_apply  = sw_pend_q && (tick_q == '0);     // Only at sweep start
   assign bank_rd   = sw_apply ? bank_t'(bank_q + 1'b1) : bank_q;

   // -------------------------------------------------------------------------
   // Tick counter, bank and clear
   // -------------------------------------------------------------------------
   always_ff @(posedge sram_ck_i) begin
      if (reset_i) begin
         tick_q <= '0;
      end else if (en_i) begin
         tick_q <= tick_last ? '0 : tick_t'(tick_q + 1'b1);   // Wrap at TRATE-1
      end
   end

   always_ff @(posedge sram_ck_i) begin
      if (reset_i) begin
         bank_q    <= '0;
         sw_pend_q <= 1'b0;
         clear_q   <= 1'b1;                    // First sweep after reset clears
      end else begin
         sw_pend_q <= sw_i || (sw_pend_q && !sw_apply);
         if (sw_apply) begin
            bank_q  <= bank_rd;
            clear_q <= 1'b1;                   // Held for one full sweep
         end else if (en_i && tick_last) begin
            clear_q <= 1'b0;                   // Sweep done, accumulate from now
         end
      end
   end

   // 2-cycle copy for the write side
   always_ff @(posedge sram_ck_i) begin
      if (reset_i) begin
         en_d1_q   <= 1'b0;
         en_d2_q   <= 1'b0;
         tick_d1_q <= '0;
         tick_d2_q <= '0;
         bank_d1_q <= '0;
         bank_d2_q <= '0;
      end else begin
         en_d1_q   <= en_i;
         en_d2_q   <= en_d1_q;
         tick_d1_q <= tick_q;
         tick_d2_q <= tick_d1_q;
         bank_d1_q <= bank_rd;
         bank_d2_q <= bank_d1_q;
      end
   end

   assign ctl.rd_en   = en_i;
   assign ctl.rd_tick = tick_q;
   assign ctl.clear   = clear_q || sw_apply;   // Covers a switch at this tick 0
   assign ctl.wr_en   = en_d2_q;
   assign ctl.wr_tick = tick_d2_q;
   assign ctl.wr_bank = bank_d2_q;

endmodule

// File: logic/corr_ctrl_if.sv
`timescale 1ns/1ps

interface corr_ctrl_if import corr_pkg::*; ();

   // Read side, valid in the cycle the sample is on re_i/im_i
   logic  rd_en;                               // Sample processed this cycle
   tick_t rd_tick;                             // Selects pair and accumulator
   logic  clear;                               // First sweep of a bank

   // Write side, rd_en/rd_tick/bank two cycles later
   logic  wr_en;
   tick_t wr_tick;
   bank_t wr_bank;

   modport ctrl (
      output rd_en, rd_tick, clear,
      output wr_en, wr_tick, wr_bank
   );

   modport blk (
      input  rd_en, rd_tick, clear,
      input  wr_en, wr_tick, wr_bank
   );

endinterface

// File: logic/corr_pkg.sv
package corr_pkg;

   // -------------------------------------------------------------------------
   // Widths
   // -------------------------------------------------------------------------
   localparam int ACCUM     = 24;              // Accumulator width
   localparam int IBITS     = 24;              // Number of antennas
   localparam int TRATE     = 12;              // Ticks per sweep
   localparam int TBITS     = 4;               // Tick counter width
   localparam int XBITS     = 4;               // Bank address width
   localparam int NCORR     = 4;               // Correlators on one stream
   localparam int SEL_BITS  = 3;               // Correlator index plus Re/Im bit
   localparam int ANT_BITS  = 5;               // Antenna index width
   localparam int PAIR_BITS = 2 * ANT_BITS;    // One packed pair-table entry

   // Agreement rule, each increment sums two 1-bit agreements
   localparam int INC_BITS  = 2;               // Increment is 0, 1 or 2

   // -------------------------------------------------------------------------
   // Types
   // -------------------------------------------------------------------------
   typedef logic [ACCUM-1:0]     acc_t;
   typedef logic [2*ACCUM-1:0]   vis_t;        // {imag, real}
   typedef logic [IBITS-1:0]     sample_t;     // One bit per antenna
   typedef logic [TBITS-1:0]     tick_t;
   typedef logic [XBITS-1:0]     bank_t;
   typedef logic [INC_BITS-1:0]  inc_t;

   // Read-back address, {bank, tick, correlator, component}
   typedef logic [XBITS+TBITS+SEL_BITS-1:0] sram_adr_t;

   typedef logic [ANT_BITS-1:0]  ant_t;

   // Entry t sits at bits [t*PAIR_BITS +: PAIR_BITS], first antenna high
   typedef logic [TRATE*PAIR_BITS-1:0] pair_tab_t;

endpackage
